//--- logic/mshr_config.svh
`ifndef MSHR_CONFIG_SVH
`define MSHR_CONFIG_SVH

// Miss table geometry.
`define MSHR_DEPTH 8
`define MSHR_PTR_W 3

// One line is four bus words.
`define LINE_WORDS 4
`define LINE_BITS 128

// Line address split, tag above index.
`define TAG_W 23
`define INDEX_W 5

`endif

//--- logic/mshr_pkg.sv
`default_nettype none

`include "mshr_config.svh"

package mshr_pkg;

    // Wishbone data width.
    localparam int WORD_W = 32;

    // Word position within a line.
    localparam int BEAT_W = $clog2(`LINE_WORDS);

    // Word address on the bus, line address plus beat.
    localparam int WB_ADR_W = `TAG_W + `INDEX_W + BEAT_W;

    typedef struct packed {
        logic [`TAG_W-1:0]   tag;
        logic [`INDEX_W-1:0] index;
    } line_fields_t;

    // Raw view for matching, field view for the victim address.
    typedef union packed {
        logic [`TAG_W+`INDEX_W-1:0] raw;
        line_fields_t               fields;
    } line_addr_u;

endpackage

`default_nettype wire

//--- logic/mshr_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "mshr_config.svh"

module mshr_file (
    input  wire                       g,
    input  wire                       arst_n,
    input  wire                       miss_valid,
    input  wire mshr_pkg::line_addr_u miss_addr,
    input  wire                       miss_dirty,
    input  wire [`TAG_W-1:0]          victim_tag,
    input  wire [`LINE_BITS-1:0]      victim_line,
    input  wire                       head_retire,
    output logic                      miss_ready,
    output logic                      head_valid,
    output logic                      head_dirty,
    output mshr_pkg::line_addr_u      head_addr,
    output logic [`TAG_W-1:0]         head_tag,
    output logic [`LINE_BITS-1:0]     head_line
);

    logic [`MSHR_DEPTH-1:0] valid_q;
    logic [`MSHR_DEPTH-1:0] dirty_q;
    mshr_pkg::line_addr_u   addr_q [`MSHR_DEPTH];
    logic [`TAG_W-1:0]      tag_q [`MSHR_DEPTH];
    logic [`LINE_BITS-1:0]  line_q [`MSHR_DEPTH];

    logic [`MSHR_PTR_W-1:0] alloc_ptr;
    logic [`MSHR_PTR_W-1:0] head_ptr;

    logic [`MSHR_DEPTH-1:0] match;
    logic                   hit;
    logic                   full;
    logic                   alloc;

    // Compare the incoming line against every pending entry at once.
    always_comb
    begin
        for (int i = 0; i < `MSHR_DEPTH; i++)
        begin
            match[i] = valid_q[i] && (addr_q[i].raw == miss_addr.raw);
        end
    end

    assign hit   = |match;
    assign full  = valid_q[alloc_ptr];
    assign miss_ready = hit || !full;

    // A merged miss takes no entry.
    assign alloc = miss_valid && miss_ready && !hit;

    always_ff @(posedge g or negedge arst_n)
    begin
        if (!arst_n)
        begin
            valid_q   <= '0;
            alloc_ptr <= '0;
            head_ptr  <= '0;
        end
        else
        begin
            if (head_retire)
            begin
                valid_q[head_ptr] <= 1'b0;
                head_ptr          <= head_ptr + 1'b1;
            end
            if (alloc)
            begin
                valid_q[alloc_ptr] <= 1'b1;
                alloc_ptr          <= alloc_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge g)
    begin
        if (alloc)
        begin
            dirty_q[alloc_ptr] <= miss_dirty;
            addr_q[alloc_ptr]  <= miss_addr;
            tag_q[alloc_ptr]   <= victim_tag;
            line_q[alloc_ptr]  <= victim_line;
        end
    end

    // The oldest entry is the one on the bus.
    assign head_valid = valid_q[head_ptr];
    assign head_dirty = dirty_q[head_ptr];
    assign head_addr  = addr_q[head_ptr];
    assign head_tag   = tag_q[head_ptr];
    assign head_line  = line_q[head_ptr];

endmodule

`default_nettype wire

//--- logic/beat_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "mshr_config.svh"

module beat_counter (
    input  wire                         g,
    input  wire                         arst_n,
    input  wire                         start,
    input  wire                         step,
    output logic [mshr_pkg::BEAT_W-1:0] beat,
    output logic                        last_beat
);

    always_ff @(posedge g or negedge arst_n)
    begin
        if (!arst_n)
            beat <= '0;
        else if (start)
            beat <= '0;
        else if (step)
            beat <= beat + 1'b1;
    end

    // Counter wraps to zero after the final word, ready for the next phase.
    assign last_beat = (beat == mshr_pkg::BEAT_W'(`LINE_WORDS - 1));

endmodule

`default_nettype wire

//--- logic/line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "mshr_config.svh"

module line_buffer (
    input  wire                         g,
    input  wire                         arst_n,
    input  wire [`LINE_BITS-1:0]        head_line,
    input  wire [mshr_pkg::BEAT_W-1:0]  beat,
    input  wire                         capture,
    input  wire [mshr_pkg::WORD_W-1:0]  wb_rdata,
    output logic [mshr_pkg::WORD_W-1:0] wr_word,
    output logic [`LINE_BITS-1:0]       fill_line
);

    // Word 0 sits in the low bits of a line.
    assign wr_word = head_line[beat*mshr_pkg::WORD_W +: mshr_pkg::WORD_W];

    always_ff @(posedge g or negedge arst_n)
    begin
        if (!arst_n)
        begin
            fill_line <= '0;
        end
        else if (capture)
        begin
            fill_line[beat*mshr_pkg::WORD_W +: mshr_pkg::WORD_W] <= wb_rdata;
        end
    end

endmodule

`default_nettype wire

//--- logic/miss_fill_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "mshr_config.svh"

module miss_fill_fsm (
    input  wire                            g,
    input  wire                            arst_n,
    input  wire                            head_valid,
    input  wire                            head_dirty,
    input  wire mshr_pkg::line_addr_u      head_addr,
    input  wire [`TAG_W-1:0]               head_tag,
    input  wire                            last_beat,
    input  wire [mshr_pkg::BEAT_W-1:0]     beat,
    input  wire [mshr_pkg::WORD_W-1:0]     wr_word,
    input  wire                            wb_ack,
    output logic                           wb_cyc,
    output logic                           wb_stb,
    output logic                           wb_we,
    output logic [mshr_pkg::WB_ADR_W-1:0]  wb_adr,
    output logic [mshr_pkg::WORD_W-1:0]    wb_wdata,
    output logic                           count_start,
    output logic                           count_step,
    output logic                           capture,
    output logic                           refill_valid,
    output mshr_pkg::line_addr_u           refill_addr,
    output logic                           head_retire
);

    localparam logic [2:0] S_IDLE   = 3'd0;
    localparam logic [2:0] S_WB_REQ = 3'd1;
    localparam logic [2:0] S_WB_GAP = 3'd2;
    localparam logic [2:0] S_RD_REQ = 3'd3;
    localparam logic [2:0] S_RD_GAP = 3'd4;
    localparam logic [2:0] S_REFILL = 3'd5;

    logic [2:0] state_q;
    logic [2:0] state_d;

    always_ff @(posedge g or negedge arst_n)
    begin
        if (!arst_n)
            state_q <= S_IDLE;
        else
            state_q <= state_d;
    end

    always_comb
    begin
        state_d     = state_q;
        count_start = 1'b0;
        count_step  = 1'b0;
        capture     = 1'b0;
        case (state_q)
            S_IDLE:
            begin
                if (head_valid)
                begin
                    count_start = 1'b1;
                    state_d     = head_dirty ? S_WB_REQ : S_RD_REQ;
                end
            end
            S_WB_REQ:
            begin
                // Last write ack hands over to the read phase after a gap.
                if (wb_ack)
                begin
                    count_step = 1'b1;
                    state_d    = last_beat ? S_RD_GAP : S_WB_GAP;
                end
            end
            S_WB_GAP: state_d = S_WB_REQ;
            S_RD_REQ:
            begin
                if (wb_ack)
                begin
                    count_step = 1'b1;
                    capture    = 1'b1;
                    state_d    = last_beat ? S_REFILL : S_RD_GAP;
                end
            end
            S_RD_GAP: state_d = S_RD_REQ;
            S_REFILL: state_d = S_IDLE;
            default:  state_d = S_IDLE;
        endcase
    end

    assign wb_cyc = (state_q == S_WB_REQ) || (state_q == S_RD_REQ);
    assign wb_stb = wb_cyc;
    assign wb_we  = (state_q == S_WB_REQ);

    // Writeback goes to the victim's line, built from its tag and our index.
    assign wb_adr = wb_we ? {head_tag, head_addr.fields.index, beat} : {head_addr.raw, beat};
    assign wb_wdata = wb_we ? wr_word : '0;

    assign refill_valid = (state_q == S_REFILL);
    assign head_retire  = (state_q == S_REFILL);
    assign refill_addr  = head_addr;

endmodule

`default_nettype wire

//--- logic/miss_handler_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mshr_config.svh"

module miss_handler_top (
    input  wire                            g,
    input  wire                            arst_n,
    input  wire                            miss_valid,
    input  wire mshr_pkg::line_addr_u      miss_addr,
    input  wire                            miss_dirty,
    input  wire [`TAG_W-1:0]               victim_tag,
    input  wire [`LINE_BITS-1:0]           victim_line,
    output logic                           miss_ready,
    output logic                           refill_valid,
    output mshr_pkg::line_addr_u           refill_addr,
    output logic [`LINE_BITS-1:0]          refill_line,
    output logic                           wb_cyc,
    output logic                           wb_stb,
    output logic                           wb_we,
    output logic [mshr_pkg::WB_ADR_W-1:0]  wb_adr,
    output logic [mshr_pkg::WORD_W-1:0]    wb_wdata,
    input  wire [mshr_pkg::WORD_W-1:0]     wb_rdata,
    input  wire                            wb_ack
);

    logic                        head_valid;
    logic                        head_dirty;
    mshr_pkg::line_addr_u        head_addr;
    logic [`TAG_W-1:0]           head_tag;
    logic [`LINE_BITS-1:0]       head_line;
    logic                        head_retire;
    logic                        count_start;
    logic                        count_step;
    logic [mshr_pkg::BEAT_W-1:0] beat;
    logic                        last_beat;
    logic                        capture;
    logic [mshr_pkg::WORD_W-1:0] wr_word;

    mshr_file u_mshr_file (
        .g           (g),
        .arst_n      (arst_n),
        .miss_valid  (miss_valid),
        .miss_addr   (miss_addr),
        .miss_dirty  (miss_dirty),
        .victim_tag  (victim_tag),
        .victim_line (victim_line),
        .head_retire (head_retire),
        .miss_ready  (miss_ready),
        .head_valid  (head_valid),
        .head_dirty  (head_dirty),
        .head_addr   (head_addr),
        .head_tag    (head_tag),
        .head_line   (head_line)
    );

    miss_fill_fsm u_fsm (
        .g            (g),
        .arst_n       (arst_n),
        .head_valid   (head_valid),
        .head_dirty   (head_dirty),
        .head_addr    (head_addr),
        .head_tag     (head_tag),
        .last_beat    (last_beat),
        .beat         (beat),
        .wr_word      (wr_word),
        .wb_ack       (wb_ack),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_wdata     (wb_wdata),
        .count_start  (count_start),
        .count_step   (count_step),
        .capture      (capture),
        .refill_valid (refill_valid),
        .refill_addr  (refill_addr),
        .head_retire  (head_retire)
    );

    beat_counter u_beat_counter (
        .g         (g),
        .arst_n    (arst_n),
        .start     (count_start),
        .step      (count_step),
        .beat      (beat),
        .last_beat (last_beat)
    );

    // The assembled line is the refill payload.
    line_buffer u_line_buffer (
        .g         (g),
        .arst_n    (arst_n),
        .head_line (head_line),
        .beat      (beat),
        .capture   (capture),
        .wb_rdata  (wb_rdata),
        .wr_word   (wr_word),
        .fill_line (refill_line)
    );

endmodule

`default_nettype wire

//--- verif/miss_handler_sva.sv
`timescale 1ns/1ps
`default_nettype none

module miss_handler_sva (
    input wire                            g,
    input wire                            arst_n,
    input wire                            wb_cyc,
    input wire                            wb_stb,
    input wire                            wb_we,
    input wire [mshr_pkg::WB_ADR_W-1:0]   wb_adr,
    input wire [mshr_pkg::WORD_W-1:0]     wb_wdata,
    input wire                            wb_ack,
    input wire                            refill_valid
);

    stb_needs_cyc: assert property (@(posedge g) disable iff (!arst_n)
        wb_stb |-> wb_cyc)
        else $error("wb_stb high without wb_cyc");

    // A request holds its address, direction and data until the slave acks.
    req_stable: assert property (@(posedge g) disable iff (!arst_n)
        (wb_stb && !wb_ack) |=>
            (wb_stb && $stable(wb_adr) && $stable(wb_we) && $stable(wb_wdata)))
        else $error("Wishbone request changed before ack");

    refill_one_cycle: assert property (@(posedge g) disable iff (!arst_n)
        refill_valid |=> !refill_valid)
        else $error("refill_valid held for two cycles");

endmodule

bind miss_handler_top miss_handler_sva u_sva (.*);

`default_nettype wire

//--- verif/miss_handler_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mshr_config.svh"

module miss_handler_tb;

    localparam int LA_W          = `TAG_W + `INDEX_W;
    localparam int ADR_W         = mshr_pkg::WB_ADR_W;
    localparam int ROWS          = 13;
    localparam int TAKE_TIMEOUT  = 200;
    localparam int DRAIN_TIMEOUT = 2000;

    typedef struct packed {
        logic [LA_W-1:0]        addr;
        logic                   dirty;
        logic [`TAG_W-1:0]      tag;
        logic [`LINE_BITS-1:0]  line;
        logic                   refill;
    } row_t;

    // Line address, dirty, victim tag, victim line, refill expected.
    row_t rows [ROWS] = '{
        '{28'h00012A3, 1'b0, 23'h000000, 128'h0, 1'b1},
        '{28'h00012A3, 1'b0, 23'h000000, 128'h0, 1'b0},
        '{28'h0003405, 1'b1, 23'h000777, 128'hD00D_0003_D00D_0002_D00D_0001_D00D_0000, 1'b1},
        '{28'h000EEE5, 1'b0, 23'h000000, 128'h0, 1'b1},
        '{28'h0100001, 1'b0, 23'h000000, 128'h0, 1'b1},
        '{28'h0100022, 1'b0, 23'h000000, 128'h0, 1'b1},
        '{28'h0100043, 1'b1, 23'h0ABCDE, 128'hCAFE_0013_CAFE_0012_CAFE_0011_CAFE_0010, 1'b1},
        '{28'h0100064, 1'b0, 23'h000000, 128'h0, 1'b1},
        '{28'h0100085, 1'b0, 23'h000000, 128'h0, 1'b1},
        '{28'h01000A6, 1'b0, 23'h000000, 128'h0, 1'b1},
        '{28'h01000C7, 1'b1, 23'h012345, 128'hBEEF_0023_BEEF_0022_BEEF_0021_BEEF_0020, 1'b1},
        '{28'h01000E8, 1'b0, 23'h000000, 128'h0, 1'b1},
        '{28'h0100109, 1'b0, 23'h000000, 128'h0, 1'b1}
    };

    logic                        g;
    logic                        arst_n;
    logic                        miss_valid;
    mshr_pkg::line_addr_u        miss_addr;
    logic                        miss_dirty;
    logic [`TAG_W-1:0]           victim_tag;
    logic [`LINE_BITS-1:0]       victim_line;
    logic                        miss_ready;
    logic                        refill_valid;
    mshr_pkg::line_addr_u        refill_addr;
    logic [`LINE_BITS-1:0]       refill_line;
    logic                        wb_cyc;
    logic                        wb_stb;
    logic                        wb_we;
    logic [ADR_W-1:0]            wb_adr;
    logic [mshr_pkg::WORD_W-1:0] wb_wdata;
    logic [mshr_pkg::WORD_W-1:0] wb_rdata = '0;
    logic                        wb_ack = 1'b0;

    logic                        exp_we [$];
    logic [ADR_W-1:0]            exp_adr [$];
    logic [mshr_pkg::WORD_W-1:0] exp_wdata [$];
    logic [LA_W-1:0]             exp_raddr [$];
    logic [`LINE_BITS-1:0]       exp_rline [$];
    logic [mshr_pkg::WORD_W-1:0] exp_mem [logic [ADR_W-1:0]];
    logic [mshr_pkg::WORD_W-1:0] mem [logic [ADR_W-1:0]];
    logic [LA_W-1:0]             pend [$];

    logic [7:0] lfsr = 8'd82;
    logic [1:0] wait_left = 2'd0;
    logic       busy = 1'b0;
    logic       stall_seen = 1'b0;
    int         bus_idx = 0;
    int         refill_idx = 0;

    miss_handler_top u_dut (.*);

    initial
    begin
        g = 1'b0;
        forever #5 g = ~g;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
            abort_run($sformatf("error at %0t: %s got %b expected %b", $time, what, got, exp));
    endtask

    task automatic check_word(input logic [mshr_pkg::WORD_W-1:0] got,
                              input logic [mshr_pkg::WORD_W-1:0] exp, input string what);
        if (got !== exp)
            abort_run($sformatf("error at %0t: %s got %h expected %h", $time, what, got, exp));
    endtask

    task automatic check_bus_adr(input logic [ADR_W-1:0] got,
                                 input logic [ADR_W-1:0] exp, input string what);
        if (got !== exp)
            abort_run($sformatf("error at %0t: %s got %h expected %h", $time, what, got, exp));
    endtask

    task automatic check_addr(input mshr_pkg::line_addr_u got,
                              input mshr_pkg::line_addr_u exp, input string what);
        if (got.raw !== exp.raw)
            abort_run($sformatf("error at %0t: %s got %h expected %h",
                                $time, what, got.raw, exp.raw));
    endtask

    task automatic check_line(input logic [`LINE_BITS-1:0] got,
                              input logic [`LINE_BITS-1:0] exp, input string what);
        if (got !== exp)
            abort_run($sformatf("error at %0t: %s got %h expected %h", $time, what, got, exp));
    endtask

    function automatic logic [mshr_pkg::WORD_W-1:0] fill_word(input logic [ADR_W-1:0] a);
        return mshr_pkg::WORD_W'(a) ^ 32'h5A5A_0000;
    endfunction

    // Fibonacci LFSR with taps 8 6 5 4.
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];
        lfsr = {lfsr[6:0], fb};
        return fb;
    endfunction

    function automatic logic [1:0] ack_delay();
        logic hi;
        logic lo;
        hi = lfsr_step();
        lo = lfsr_step();
        return {hi, lo};
    endfunction

    // Entries are served in order, so the bus and refill streams follow the table.
    task automatic build_expect();
        logic [ADR_W-1:0]      a;
        logic [`LINE_BITS-1:0] line;
        for (int r = 0; r < ROWS; r++)
        begin
            if (rows[r].refill)
            begin
                if (rows[r].dirty)
                begin
                    for (int b = 0; b < `LINE_WORDS; b++)
                    begin
                        a = {rows[r].tag, rows[r].addr[`INDEX_W-1:0], b[1:0]};
                        exp_mem[a] = rows[r].line[b*mshr_pkg::WORD_W +: mshr_pkg::WORD_W];
                        exp_we.push_back(1'b1);
                        exp_adr.push_back(a);
                        exp_wdata.push_back(exp_mem[a]);
                    end
                end
                for (int b = 0; b < `LINE_WORDS; b++)
                begin
                    a = {rows[r].addr, b[1:0]};
                    line[b*mshr_pkg::WORD_W +: mshr_pkg::WORD_W] =
                        exp_mem.exists(a) ? exp_mem[a] : fill_word(a);
                    exp_we.push_back(1'b0);
                    exp_adr.push_back(a);
                    exp_wdata.push_back('0);
                end
                exp_raddr.push_back(rows[r].addr);
                exp_rline.push_back(line);
            end
        end
    endtask

    // Wishbone slave with a random ack delay that also checks every transfer.
    always @(posedge g)
    begin
        if (!arst_n)
        begin
            wb_ack <= 1'b0;
            busy = 1'b0;
        end
        else if (wb_ack)
        begin
            if (bus_idx >= exp_we.size())
                abort_run("A bus cycle ran that no pending miss should cause");
            check_flag(wb_we, exp_we[bus_idx], "wb_we");
            check_bus_adr(wb_adr, exp_adr[bus_idx], "wb_adr");
            if (wb_we)
            begin
                check_word(wb_wdata, exp_wdata[bus_idx], "wb_wdata");
                mem[wb_adr] = wb_wdata;
            end
            bus_idx++;
            wb_ack <= 1'b0;
            busy = 1'b0;
        end
        else if (wb_stb)
        begin
            if (!busy)
            begin
                wait_left = ack_delay();
                busy = 1'b1;
            end
            if (wait_left == 2'd0)
            begin
                wb_ack   <= 1'b1;
                wb_rdata <= mem.exists(wb_adr) ? mem[wb_adr] : fill_word(wb_adr);
            end
            else
                wait_left = wait_left - 1'b1;
        end
    end

    // Model of the pending table checks miss_ready each cycle and the refill order.
    always @(posedge g)
    begin : monitor
        logic                 hit;
        mshr_pkg::line_addr_u ea;
        if (arst_n)
        begin
            hit = 1'b0;
            foreach (pend[i])
                if (pend[i] == miss_addr.raw)
                    hit = 1'b1;
            check_flag(miss_ready, hit || (pend.size() < `MSHR_DEPTH), "miss_ready");
            if (!miss_ready)
                stall_seen = 1'b1;
            if (miss_valid && miss_ready && !hit)
                pend.push_back(miss_addr.raw);
            if (refill_valid)
            begin
                if (refill_idx >= exp_raddr.size())
                    abort_run("A refill arrived that no pending miss should produce");
                ea.raw = exp_raddr[refill_idx];
                check_addr(refill_addr, ea, "refill_addr");
                check_line(refill_line, exp_rline[refill_idx], "refill_line");
                refill_idx++;
                void'(pend.pop_front());
            end
        end
    end

    initial
    begin : stimulus
        int waited;
        arst_n      <= 1'b0;
        miss_valid  <= 1'b0;
        miss_addr   <= '0;
        miss_dirty  <= 1'b0;
        victim_tag  <= '0;
        victim_line <= '0;
        build_expect();
        repeat (16) @(posedge g);
        arst_n <= 1'b1;
        @(posedge g);
        check_flag(wb_cyc, 1'b0, "wb_cyc after reset");
        check_flag(wb_stb, 1'b0, "wb_stb after reset");
        check_flag(refill_valid, 1'b0, "refill_valid after reset");
        check_flag(miss_ready, 1'b1, "miss_ready after reset");

        // Rows go back to back and each is held until the table takes it.
        for (int r = 0; r < ROWS; r++)
        begin
            miss_valid    <= 1'b1;
            miss_addr.raw <= rows[r].addr;
            miss_dirty    <= rows[r].dirty;
            victim_tag    <= rows[r].tag;
            victim_line   <= rows[r].line;
            waited = 0;
            do
            begin
                @(posedge g);
                waited++;
                if (waited > TAKE_TIMEOUT)
                    abort_run("Timed out waiting for the table to take a miss");
            end
            while (!miss_ready);
        end
        miss_valid <= 1'b0;

        waited = 0;
        while (refill_idx < exp_raddr.size())
        begin
            @(posedge g);
            waited++;
            if (waited > DRAIN_TIMEOUT)
                abort_run("Timed out waiting for the outstanding refills");
        end
        // Quiet period so any extra bus cycle or refill gets caught.
        repeat (20) @(posedge g);

        if (bus_idx != exp_we.size() || !stall_seen)
            abort_run("Bus cycles went missing or the full table never stalled a miss");
        else
        begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+logic
logic/mshr_pkg.sv
logic/mshr_file.sv
logic/beat_counter.sv
logic/line_buffer.sv
logic/miss_fill_fsm.sv
logic/miss_handler_top.sv
verif/miss_handler_sva.sv
verif/miss_handler_tb.sv

//--- Makefile
VERILATOR  ?= verilator
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
TOP        := miss_handler_tb
FILELIST   := compile.f
BUILD_DIR  := obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
